/* tc_mul_vectors.txt */
// columns: rm a0 a1 a2 a3 b0 b1 b2 b3 reg_idx warp_id r0 r1 r2 r3 flags
// all hex, flags are nv of uf nx from msb to lsb
0 078 07C 079 07A 078 07C 079 07A 01 0 078 081 07A 07C 1
0 079 079 080 178 07C 07E 084 07C 02 1 07E 080 08C 17C 1
1 079 079 080 178 07C 07E 084 07C 03 2 07D 07F 08C 17C 1
0 07B 07F 07D 07E 07B 07F 07D 07E 04 3 07F 086 083 084 1
1 07B 07F 07D 07E 07B 07F 07D 07E 05 4 07F 086 082 084 1
0 0FC 0F9 0F8 1F8 078 078 000 080 06 5 0FC 0FC 0FC 1F8 8
0 0F8 100 178 005 178 07C 000 078 07 6 1F8 100 100 000 0
1 0FC 000 0F9 1FC 0F8 1F8 000 178 08 7 0FC 0FC 0FC 0FC 8
0 0F0 1F0 079 0F0 0F0 0F0 0F6 080 09 0 0F8 1F8 0F8 0F8 5
1 0F0 1F0 079 0F0 0F0 0F0 0F6 080 0a 1 0F7 1F7 0F7 0F7 5
0 008 108 038 03C 008 008 040 044 0b 2 000 100 000 009 3
0 0F9 0F0 008 078 078 0F0 008 078 0c 3 0FC 0F8 000 078 F
1 078 07C 0F8 100 078 078 078 100 0d 4 078 07C 0F8 000 0
0 084 082 07E 0F7 084 082 080 078 0e 5 091 08C 086 0F7 1
1 07E 07E 1F8 0FC 07E 07B 1F8 078 ff 7 084 081 0F8 0FC 1

/* tc_mul_top.f */
tc_mul_pkg.sv
tc_mul_issue.sv
fp_mul_lane.sv
tc_mul_collect.sv
tc_mul_top.sv
tc_mul_top_tb.sv

/* Bender.yml */
package:
  name: tc_mul

sources:
  - tc_mul_pkg.sv
  - tc_mul_issue.sv
  - fp_mul_lane.sv
  - tc_mul_collect.sv
  - tc_mul_top.sv
  - target: test
    files:
      - tc_mul_top_tb.sv

/* tc_mul_top_tb.sv */
// self-checking testbench for tc_mul_top, driven from the vector file
`default_nettype none

module tc_mul_top_tb import tc_mul_pkg::*; ();

    localparam int CLK_PERIOD = 20;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    logic     in_ready;
    mul_req_t req;
    logic     out_valid;
    logic     out_ready;
    mul_rsp_t rsp;

    mul_req_t req_q[$];
    mul_rsp_t exp_q[$];
    mul_rsp_t pend_q[$];
    integer   seed;
    int       errors;
    int       n_vec;
    int       n_sent;
    int       n_recv;
    logic     loaded;
    logic     drained;

    tc_mul_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .req_i       (req),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready),
        .rsp_o       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("Error at time %0t: %s: got %h, expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic compare_response(input mul_rsp_t got, input mul_rsp_t expected);
        for (int i = 0; i < LANES; i++) begin
            check_value($sformatf("lane %0d result", i), got.result[i], expected.result[i]);
        end
        check_value("merged flags", got.flags, expected.flags);
        check_value("tag", got.tag, expected.tag);
    endtask

    task automatic load_vectors();
        int                fd;
        int                n;
        string             line;
        logic [2:0]        rm_v;
        logic [FP_W-1:0]   av [LANES];
        logic [FP_W-1:0]   bv [LANES];
        logic [FP_W-1:0]   rv [LANES];
        logic [REG_IDX_W-1:0] ri;
        logic [WARP_ID_W-1:0] wi;
        logic [3:0]        fl;
        mul_req_t          rq;
        mul_rsp_t          rs;
        fd = $fopen("tc_mul_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tc_mul_vectors.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.substr(0, 1) != "//") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                rm_v, av[0], av[1], av[2], av[3], bv[0], bv[1], bv[2], bv[3],
                                ri, wi, rv[0], rv[1], rv[2], rv[3], fl);
                    if (n != 16) begin
                        $display("malformed line in vector file: %s", line);
                        errors++;
                    end else begin
                        rq.rm = rm_e'(rm_v);
                        for (int i = 0; i < LANES; i++) begin
                            rq.a[i]      = av[i];
                            rq.b[i]      = bv[i];
                            rs.result[i] = rv[i];
                        end
                        rq.tag.reg_idx = ri;
                        rq.tag.warp_id = wi;
                        rs.flags       = fflags_t'(fl);
                        rs.tag         = rq.tag;
                        req_q.push_back(rq);
                        exp_q.push_back(rs);
                    end
                end
            end
            $fclose(fd);
        end
        n_vec = req_q.size();
    endtask

    // inputs change 2 units after the edge, handshakes are sampled at the falling edge
    task automatic drive_requests();
        int   idx;
        logic taken;
        idx   = 0;
        taken = 1'b0;
        while (!drained) begin
            @(posedge clk);
            #2;
            out_ready = ($random(seed) & 3) != 0;
            if (taken || !in_valid) begin
                if (idx < n_vec && ($random(seed) & 7) != 0) begin
                    in_valid = 1'b1;
                    req      = req_q[idx];
                end else begin
                    in_valid = 1'b0;
                end
            end
            @(negedge clk);
            taken = in_valid && in_ready;
            if (taken) begin
                pend_q.push_back(exp_q[idx]);
                idx++;
                n_sent++;
            end
        end
    endtask

    task automatic watch_responses();
        mul_rsp_t held_rsp;
        mul_rsp_t exp_rsp;
        logic     held;
        held = 1'b0;
        while (n_recv < n_vec) begin
            @(negedge clk);
            if (held) begin
                check_value("out_valid under back-pressure", out_valid, 1'b1);
                check_value("rsp under back-pressure", rsp, held_rsp);
            end
            held     = out_valid && !out_ready;
            held_rsp = rsp;
            if (out_valid && out_ready) begin
                if (pend_q.size() == 0) begin
                    $display("a response arrived with no request outstanding");
                    errors++;
                end else begin
                    exp_rsp = pend_q.pop_front();
                    compare_response(rsp, exp_rsp);
                end
                n_recv++;
            end
        end
        // nothing may follow the last response
        repeat (4) begin
            @(negedge clk);
            check_value("out_valid after last response", out_valid, 1'b0);
        end
        drained = 1'b1;
    endtask

    initial begin
        seed      = 32'h48451c0f;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        req       = '0;
        errors    = 0;
        n_sent    = 0;
        n_recv    = 0;
        loaded    = 1'b0;
        drained   = 1'b0;
        load_vectors();
        loaded = 1'b1;
        repeat (4) begin
            @(posedge clk);
            #2;
            check_value("out_valid during reset", out_valid, 1'b0);
            check_value("in_ready during reset", in_ready, 1'b1);
        end
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        check_value("out_valid after reset", out_valid, 1'b0);
        check_value("in_ready after reset", in_ready, 1'b1);
        fork
            drive_requests();
            watch_responses();
        join
        check_value("response count", n_recv, n_sent);
        check_value("request count", n_sent, n_vec);
        $display("errors: %0d, requests: %0d, responses: %0d", errors, n_sent, n_recv);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        #(CLK_PERIOD * (20 * n_vec + 20));
        $display("Timeout: the run did not finish, %0d of %0d responses seen", n_recv, n_vec);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tc_mul_top.sv */
// top level tying issue, the multiplier lane array and collect together
`default_nettype none

module tc_mul_top import tc_mul_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  mul_req_t req_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output mul_rsp_t rsp_o
);

    logic                     en1;
    logic                     en2;
    fp_unpacked_t [LANES-1:0] opa;
    fp_unpacked_t [LANES-1:0] opb;
    rm_e                      rm;
    fp_t          [LANES-1:0] lane_result;
    fflags_t      [LANES-1:0] lane_flags;

    tc_mul_issue u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (in_valid_i),
        .req_i       (req_i),
        .out_ready_i (out_ready_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .en1_o       (en1),
        .en2_o       (en2),
        .opa_o       (opa),
        .opb_o       (opb),
        .rm_o        (rm)
    );

    for (genvar i = 0; i < LANES; i++) begin : gen_lane
        fp_mul_lane u_lane (
            .clk      (clk),
            .rst_n    (rst_n),
            .en1_i    (en1),
            .en2_i    (en2),
            .opa_i    (opa[i]),
            .opb_i    (opb[i]),
            .rm_i     (rm),
            .result_o (lane_result[i]),
            .flags_o  (lane_flags[i])
        );
    end

    tc_mul_collect u_collect (
        .clk           (clk),
        .rst_n         (rst_n),
        .en1_i         (en1),
        .en2_i         (en2),
        .tag_i         (req_i.tag),
        .lane_result_i (lane_result),
        .lane_flags_i  (lane_flags),
        .out_valid_i   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .rsp_o         (rsp_o)
    );

endmodule

`default_nettype wire

/* tc_mul_collect.sv */
// tag delay pipeline, lane flag merge and response packing
`default_nettype none

module tc_mul_collect import tc_mul_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en1_i,
    input  logic                 en2_i,
    input  tag_t                 tag_i,
    input  fp_t     [LANES-1:0]  lane_result_i,
    input  fflags_t [LANES-1:0]  lane_flags_i,
    input  logic                 out_valid_i,
    input  logic                 out_ready_i,
    output mul_rsp_t             rsp_o
);

    tag_t    tag_s1;
    tag_t    tag_s2;
    fflags_t flags_or;

    // same enables as the lanes keep the tag aligned
    always_ff @(posedge clk) begin
        if (en1_i) begin
            tag_s1 <= tag_i;
        end
        if (en2_i) begin
            tag_s2 <= tag_s1;
        end
    end

    always_comb begin
        flags_or = '0;
        for (int i = 0; i < LANES; i++) begin
            flags_or = flags_or | lane_flags_i[i];
        end
    end

    assign rsp_o.result = lane_result_i;
    assign rsp_o.flags  = flags_or;
    assign rsp_o.tag    = tag_s2;

    // response held under back-pressure
    a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid_i && !out_ready_i) |=> $stable(rsp_o));

endmodule

`default_nettype wire

/* fp_mul_lane.sv */
// two-stage half-width multiplier lane with special cases, rounding and flags
`default_nettype none

module fp_mul_lane import tc_mul_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         en1_i,
    input  logic         en2_i,
    input  fp_unpacked_t opa_i,
    input  fp_unpacked_t opb_i,
    input  rm_e          rm_i,
    output fp_t          result_o,
    output fflags_t      flags_o
);

    typedef logic signed [FP_EXP_W+1:0] sexp_t;

    typedef enum logic [1:0] {
        SC_NONE,
        SC_NAN,
        SC_INF,
        SC_ZERO
    } sc_e;

    typedef struct packed {
        sc_e                   kind;
        logic                  nv;
        logic                  sign;
        sexp_t                 exp;
        logic [2*FP_SIG_W-1:0] prod;
        rm_e                   rm;
    } s1_t;

    s1_t                  s1_d;
    s1_t                  s1_q;
    logic                 a_nan;
    logic                 b_nan;
    logic                 inf_zero;
    sexp_t                norm_exp;
    sexp_t                rnd_exp;
    logic [FP_FRAC_W-1:0] frac;
    logic [FP_FRAC_W:0]   frac_rnd;
    logic                 guard;
    logic                 sticky;
    logic                 rnd_up;
    fp_t                  result_d;
    fflags_t              flags_d;

    assign a_nan    = opa_i.cls inside {FP_QNAN_C, FP_SNAN_C};
    assign b_nan    = opb_i.cls inside {FP_QNAN_C, FP_SNAN_C};
    assign inf_zero = (opa_i.cls == FP_INF && opb_i.cls == FP_ZERO) ||
                      (opa_i.cls == FP_ZERO && opb_i.cls == FP_INF);

    always_comb begin
        s1_d.sign = opa_i.sign ^ opb_i.sign;
        s1_d.exp  = sexp_t'(opa_i.exp) + sexp_t'(opb_i.exp) - sexp_t'(FP_BIAS);
        s1_d.prod = opa_i.sig * opb_i.sig;
        s1_d.rm   = rm_i;
        s1_d.nv   = inf_zero || opa_i.cls == FP_SNAN_C || opb_i.cls == FP_SNAN_C;
        if (a_nan || b_nan || inf_zero) begin
            s1_d.kind = SC_NAN;
        end else if (opa_i.cls == FP_INF || opb_i.cls == FP_INF) begin
            s1_d.kind = SC_INF;
        end else if (opa_i.cls == FP_ZERO || opb_i.cls == FP_ZERO) begin
            s1_d.kind = SC_ZERO;
        end else begin
            s1_d.kind = SC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (en1_i) begin
            s1_q <= s1_d;
        end
    end

    // product is 2.6 fixed point, leading one at bit 7 or bit 6
    always_comb begin
        if (s1_q.prod[7]) begin
            norm_exp = s1_q.exp + sexp_t'(1);
            frac     = s1_q.prod[6:4];
            guard    = s1_q.prod[3];
            sticky   = |s1_q.prod[2:0];
        end else begin
            norm_exp = s1_q.exp;
            frac     = s1_q.prod[5:3];
            guard    = s1_q.prod[2];
            sticky   = |s1_q.prod[1:0];
        end
        rnd_up   = (s1_q.rm == RM_RNE) && guard && (sticky || frac[0]);
        frac_rnd = {1'b0, frac} + {{FP_FRAC_W{1'b0}}, rnd_up};
        rnd_exp  = norm_exp + sexp_t'(frac_rnd[FP_FRAC_W]);

        result_d.sign = s1_q.sign;
        result_d.exp  = rnd_exp[FP_EXP_W-1:0];
        result_d.frac = frac_rnd[FP_FRAC_W-1:0];
        flags_d       = '0;
        flags_d.nx    = guard || sticky;

        case (s1_q.kind)
            SC_NAN: begin
                result_d   = FP_QNAN;
                flags_d    = '0;
                flags_d.nv = s1_q.nv;
            end
            SC_INF: begin
                result_d.exp  = FP_EXP_W'(FP_EXP_MAX);
                result_d.frac = '0;
                flags_d       = '0;
            end
            SC_ZERO: begin
                result_d.exp  = '0;
                result_d.frac = '0;
                flags_d       = '0;
            end
            default: begin
                if (norm_exp <= sexp_t'(0)) begin
                    // tiny results flush to signed zero
                    result_d.exp  = '0;
                    result_d.frac = '0;
                    flags_d.uf    = 1'b1;
                    flags_d.nx    = 1'b1;
                end else if (rnd_exp >= sexp_t'(FP_EXP_MAX)) begin
                    flags_d.of = 1'b1;
                    flags_d.nx = 1'b1;
                    if (s1_q.rm == RM_RTZ) begin
                        result_d.exp  = FP_EXP_W'(FP_EXP_MAX - 1);
                        result_d.frac = '1;
                    end else begin
                        result_d.exp  = FP_EXP_W'(FP_EXP_MAX);
                        result_d.frac = '0;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_o <= '0;
            flags_o  <= '0;
        end else if (en2_i) begin
            result_o <= result_d;
            flags_o  <= flags_d;
        end
    end

    a_nan_canonical: assert property (@(posedge clk) disable iff (!rst_n)
        (result_o.exp == FP_EXP_W'(FP_EXP_MAX) && result_o.frac != '0)
            |-> result_o == FP_QNAN);

endmodule

`default_nettype wire

/* tc_mul_issue.sv */
// operand unpacking, two-stage valid tracking and stage enables
`default_nettype none

module tc_mul_issue import tc_mul_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid_i,
    input  mul_req_t                      req_i,
    input  logic                          out_ready_i,
    output logic                          in_ready_o,
    output logic                          out_valid_o,
    output logic                          en1_o,
    output logic                          en2_o,
    output fp_unpacked_t [LANES-1:0]      opa_o,
    output fp_unpacked_t [LANES-1:0]      opb_o,
    output rm_e                           rm_o
);

    logic v1;
    logic v2;
    logic hold2;

    function automatic fp_unpacked_t unpack(input logic [FP_W-1:0] raw);
        fp_t          f;
        fp_unpacked_t u;
        f      = fp_t'(raw);
        u.sign = f.sign;
        u.exp  = f.exp;
        u.sig  = {1'b1, f.frac};
        if (f.exp == '0) begin
            // subnormals flush to zero
            u.cls = FP_ZERO;
            u.sig = '0;
        end else if (f.exp == FP_EXP_W'(FP_EXP_MAX)) begin
            if (f.frac == '0) begin
                u.cls = FP_INF;
            end else if (f.frac[FP_FRAC_W-1]) begin
                u.cls = FP_QNAN_C;
            end else begin
                u.cls = FP_SNAN_C;
            end
        end else begin
            u.cls = FP_NORMAL;
        end
        return u;
    endfunction

    // stage 2 holds while its result waits downstream
    assign hold2       = v2 && !out_ready_i;
    assign in_ready_o  = !(v1 && hold2);
    assign en1_o       = in_valid_i && in_ready_o;
    assign en2_o       = v1 && !hold2;
    assign out_valid_o = v2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
        end else begin
            if (in_ready_o) begin
                v1 <= in_valid_i;
            end
            if (!hold2) begin
                v2 <= v1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            opa_o[i] = unpack(req_i.a[i]);
            opb_o[i] = unpack(req_i.b[i]);
        end
    end

    assign rm_o = req_i.rm;

    a_rm_legal: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid_i |-> req_i.rm inside {RM_RNE, RM_RTZ});

endmodule

`default_nettype wire

/* tc_mul_pkg.sv */
// format constants, enums and packed structs for the four-lane half-width multiplier
`default_nettype none

package tc_mul_pkg;

    // 1 sign, 5 exponent, 3 fraction bits
    localparam int FP_EXP_W   = 5;
    localparam int FP_FRAC_W  = 3;
    localparam int FP_W       = 1 + FP_EXP_W + FP_FRAC_W;
    localparam int FP_BIAS    = 15;
    localparam int FP_EXP_MAX = 31;
    localparam int FP_SIG_W   = FP_FRAC_W + 1;

    localparam int LANES      = 4;
    localparam int REG_IDX_W  = 8;
    localparam int WARP_ID_W  = 3;

    typedef struct packed {
        logic                 sign;
        logic [FP_EXP_W-1:0]  exp;
        logic [FP_FRAC_W-1:0] frac;
    } fp_t;

    localparam fp_t FP_QNAN = '{sign: 1'b0, exp: 5'd31, frac: 3'b100};

    typedef enum logic [2:0] {
        RM_RNE = 3'd0,
        RM_RTZ = 3'd1
    } rm_e;

    typedef enum logic [2:0] {
        FP_ZERO,
        FP_NORMAL,
        FP_INF,
        FP_QNAN_C,
        FP_SNAN_C
    } fp_class_e;

    // significand carries the hidden bit
    typedef struct packed {
        logic                sign;
        logic [FP_EXP_W-1:0] exp;
        logic [FP_SIG_W-1:0] sig;
        fp_class_e           cls;
    } fp_unpacked_t;

    typedef struct packed {
        logic nv;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef struct packed {
        logic [REG_IDX_W-1:0] reg_idx;
        logic [WARP_ID_W-1:0] warp_id;
    } tag_t;

    typedef struct packed {
        rm_e             rm;
        fp_t [LANES-1:0] a;
        fp_t [LANES-1:0] b;
        tag_t            tag;
    } mul_req_t;

    typedef struct packed {
        fp_t [LANES-1:0] result;
        fflags_t         flags;
        tag_t            tag;
    } mul_rsp_t;

endpackage

`default_nettype wire
